/* l15_adapter_pkg.sv */
// L1.5 adapter shared definitions
package l15_adapter_pkg;

    // Thread ids bound the number of requests in flight
    localparam int unsigned L15TidWidth  = 2;
    localparam int unsigned NumThreadIds = 2 ** L15TidWidth;

    localparam int unsigned PaWidth    = 40;
    localparam int unsigned PidWidth   = 3;
    localparam int unsigned MemIdWidth = 4;

    typedef logic [L15TidWidth-1:0] thid_t;
    typedef logic [PaWidth-1:0]     addr_t;
    typedef logic [PidWidth-1:0]    pid_t;
    typedef logic [MemIdWidth-1:0]  mem_id_t;
    typedef logic [63:0]            dword_t;
    typedef logic [7:0]             be_t;
    typedef logic [2:0]             size_t;   // Log2 of the byte count

    // Requests seen on the cache memory port
    typedef enum logic [1:0] {
        CMD_READ      = 2'b00,
        CMD_WRITE     = 2'b01,
        CMD_UNC_READ  = 2'b10,
        CMD_UNC_WRITE = 2'b11
    } req_cmd_e;

    // L1.5 request types, OpenPiton encoding
    typedef enum logic [4:0] {
        RQ_LOAD  = 5'b00000,
        RQ_STORE = 5'b00001
    } l15_rqtype_e;

    // L1.5 return types
    typedef enum logic [3:0] {
        RET_LOAD      = 4'b0000,
        RET_EVICT     = 4'b0011,   // Carries an invalidation only
        RET_STORE_ACK = 4'b0100,
        RET_ERR       = 4'b1100
    } l15_rtrn_e;

endpackage

/* l15_req_fsm.sv */
// L1.5 request handshake FSM
`timescale 1ns/100ps

module l15_req_fsm (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic req_valid_i,
    input  logic thid_free_i,
    input  logic l15_header_ack_i,
    input  logic l15_ack_i,
    output logic l15_val_o,
    output logic accept_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_HDR_ACK,
        WAIT_ACK
    } state_e;

    state_e state_q, state_d;

    always_comb begin
        state_d   = state_q;
        l15_val_o = 1'b0;
        accept_o  = 1'b0;
        unique case (state_q)
            IDLE: begin
                // Only start when a thread id can be handed out
                if (req_valid_i && thid_free_i) begin
                    l15_val_o = 1'b1;
                    if (l15_header_ack_i) begin
                        if (l15_ack_i) begin
                            accept_o = 1'b1;   // Both acks at once
                        end else begin
                            state_d = WAIT_ACK;
                        end
                    end else begin
                        state_d = WAIT_HDR_ACK;
                    end
                end
            end
            WAIT_HDR_ACK: begin
                l15_val_o = 1'b1;   // Keep asserting until the header is taken
                if (req_valid_i && l15_header_ack_i) begin
                    if (l15_ack_i) begin
                        accept_o = 1'b1;
                        state_d  = IDLE;
                    end else begin
                        state_d = WAIT_ACK;
                    end
                end
            end
            WAIT_ACK: begin
                // Valid drops here but the request fields stay put
                if (req_valid_i && l15_ack_i) begin
                    accept_o = 1'b1;
                    state_d  = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* l15_fifo.sv */
// Register FIFO with typed payload
`timescale 1ns/100ps

module l15_fifo #(
    parameter int unsigned Depth     = 4,
    parameter bit          InitFill  = 1'b0,
    parameter type         payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output logic     full_o,
    output logic     valid_o,
    output payload_t pop_data_o
);

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    payload_t             mem_q [Depth];
    logic [PtrWidth-1:0]  rd_ptr_q, wr_ptr_q;
    logic [CntWidth-1:0]  count_q;
    logic                 push_ok, pop_ok;

    assign full_o     = (count_q == CntWidth'(Depth));
    assign valid_o    = (count_q != '0);
    assign pop_data_o = mem_q[rd_ptr_q];

    assign pop_ok  = pop_i && valid_o;
    assign push_ok = push_i && (!full_o || pop_ok);   // Full but draining is fine

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;   // Wraps onto the read pointer when prefilled
            count_q  <= InitFill ? CntWidth'(Depth) : '0;
        end else begin
            if (pop_ok) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                count_q <= count_q + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Storage, loaded with its own indices when used as a free list
    if (InitFill) begin : g_init_mem
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                for (int i = 0; i < Depth; i++) begin
                    mem_q[i] <= payload_t'(i);
                end
            end else if (push_ok) begin
                mem_q[wr_ptr_q] <= push_data_i;
            end
        end
    end else begin : g_plain_mem
        always_ff @(posedge clk_i) begin
            if (push_ok) begin
                mem_q[wr_ptr_q] <= push_data_i;
            end
        end
    end

endmodule

/* l15_store_align.sv */
// Request field translation for L1.5
`timescale 1ns/100ps

module l15_store_align import l15_adapter_pkg::*; (
    input  req_cmd_e    req_cmd_i,
    input  addr_t       req_addr_i,
    input  size_t       req_size_i,
    input  dword_t      req_wdata_i,
    input  be_t         req_be_i,
    output l15_rqtype_e l15_rqtype_o,
    output logic        l15_nc_o,
    output size_t       l15_size_o,
    output addr_t       l15_address_o,
    output dword_t      l15_data_o
);

    logic       is_store;
    logic [2:0] low_idx;     // Lowest set byte in the mask
    logic [3:0] num_ones;
    dword_t     shifted;

    assign is_store = (req_cmd_i == CMD_WRITE) || (req_cmd_i == CMD_UNC_WRITE);
    assign l15_nc_o = (req_cmd_i == CMD_UNC_READ) || (req_cmd_i == CMD_UNC_WRITE);
    assign l15_rqtype_o = is_store ? RQ_STORE : RQ_LOAD;

    always_comb begin
        low_idx = 3'd7;
        for (int i = 7; i >= 0; i--) begin
            if (req_be_i[i]) begin
                low_idx = 3'(i);
            end
        end
    end

    assign num_ones = 4'($countones(req_be_i));
    assign shifted  = req_wdata_i >> (8 * low_idx);   // Active bytes moved to bit 0

    always_comb begin
        l15_size_o    = req_size_i;
        l15_address_o = req_addr_i;
        l15_data_o    = req_wdata_i;
        if (is_store) begin
            l15_size_o = 3'd3;   // Full dword unless the mask says otherwise
            unique case (num_ones)
                4'd1: begin
                    l15_size_o    = 3'd0;
                    l15_address_o = {req_addr_i[PaWidth-1:3], low_idx};
                    l15_data_o    = {8{shifted[7:0]}};
                end
                4'd2: begin
                    l15_size_o    = 3'd1;
                    l15_address_o = {req_addr_i[PaWidth-1:3], low_idx};
                    l15_data_o    = {4{shifted[15:0]}};
                end
                4'd4: begin
                    l15_size_o    = 3'd2;
                    l15_address_o = {req_addr_i[PaWidth-1:3], low_idx};
                    l15_data_o    = {2{shifted[31:0]}};
                end
                default: begin
                    l15_size_o = 3'd3;   // Address and data already aligned
                end
            endcase
        end
    end

endmodule

/* l15_resp_route.sv */
// L1.5 return routing and thread-id table
`timescale 1ns/100ps

module l15_resp_route import l15_adapter_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      table_wr_i,
    input  thid_t     table_thid_i,
    input  pid_t      req_pid_i,
    input  mem_id_t   req_id_i,
    input  logic      rtrn_val_i,
    input  l15_rtrn_e rtrn_type_i,
    input  thid_t     rtrn_threadid_i,
    input  logic      rtrn_inval_i,
    input  logic      inval_full_i,
    input  logic      resp_ready_i,
    output logic      l15_req_ack_o,
    output logic      resp_valid_o,
    output pid_t      resp_pid_o,
    output mem_id_t   resp_id_o,
    output logic      resp_error_o,
    output logic      thid_release_o,
    output logic      inval_push_o
);

    pid_t    pid_q [NumThreadIds];
    mem_id_t id_q  [NumThreadIds];
    logic    is_evict;

    // Requester ids indexed by L1.5 thread id
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NumThreadIds; i++) begin
                pid_q[i] <= '0;
                id_q[i]  <= '0;
            end
        end else if (table_wr_i) begin
            pid_q[table_thid_i] <= req_pid_i;
            id_q[table_thid_i]  <= req_id_i;
        end
    end

    assign is_evict = (rtrn_type_i == RET_EVICT);

    always_comb begin
        if (rtrn_inval_i) begin
            // Invalidation needs FIFO room; a pure eviction needs nothing else
            l15_req_ack_o = rtrn_val_i && !inval_full_i && (is_evict || resp_ready_i);
        end else begin
            l15_req_ack_o = rtrn_val_i && resp_ready_i;
        end
    end

    assign resp_valid_o = rtrn_val_i && !is_evict && (!rtrn_inval_i || !inval_full_i);

    assign resp_pid_o   = pid_q[rtrn_threadid_i];
    assign resp_id_o    = id_q[rtrn_threadid_i];
    assign resp_error_o = (rtrn_type_i == RET_ERR);

    assign thid_release_o = resp_valid_o && resp_ready_i;   // Response taken
    assign inval_push_o   = l15_req_ack_o && rtrn_inval_i;

endmodule

/* l15_adapter.sv */
// Cache memory port to L1.5 adapter
`timescale 1ns/100ps

module l15_adapter import l15_adapter_pkg::*; #(
    parameter int unsigned InvalFifoDepth = 4
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    // Requester side
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  pid_t        req_pid_i,
    input  mem_id_t     req_id_i,
    input  req_cmd_e    req_cmd_i,
    input  addr_t       req_addr_i,
    input  size_t       req_size_i,
    input  dword_t      req_wdata_i,
    input  be_t         req_be_i,
    // L1.5 request
    output logic        l15_val_o,
    output l15_rqtype_e l15_rqtype_o,
    output logic        l15_nc_o,
    output size_t       l15_size_o,
    output thid_t       l15_threadid_o,
    output addr_t       l15_address_o,
    output dword_t      l15_data_o,
    input  logic        l15_header_ack_i,
    input  logic        l15_ack_i,
    // L1.5 return
    input  logic        rtrn_val_i,
    input  l15_rtrn_e   rtrn_type_i,
    input  thid_t       rtrn_threadid_i,
    input  dword_t      rtrn_data_i,
    input  logic        rtrn_inval_i,
    input  addr_t       rtrn_inval_addr_i,
    output logic        l15_req_ack_o,
    // Response to requester
    output logic        resp_valid_o,
    input  logic        resp_ready_i,
    output pid_t        resp_pid_o,
    output mem_id_t     resp_id_o,
    output dword_t      resp_data_o,
    output logic        resp_error_o,
    // Invalidations
    output logic        inval_valid_o,
    input  logic        inval_ready_i,
    output addr_t       inval_addr_o
);

    logic thid_free;
    logic accept;
    logic thid_release;
    logic inval_push;
    logic inval_full;

    assign req_ready_o = accept;        // Ack cycle completes the request
    assign resp_data_o = rtrn_data_i;   // Single dword, no reshaping

    l15_req_fsm i_req_fsm (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_valid_i      (req_valid_i),
        .thid_free_i      (thid_free),
        .l15_header_ack_i (l15_header_ack_i),
        .l15_ack_i        (l15_ack_i),
        .l15_val_o        (l15_val_o),
        .accept_o         (accept)
    );

    // Head of the free list is the id of the pending request
    l15_fifo #(
        .Depth     (NumThreadIds),
        .InitFill  (1'b1),
        .payload_t (thid_t)
    ) i_thid_free_list (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (thid_release),
        .push_data_i (rtrn_threadid_i),
        .pop_i       (accept),
        .full_o      (),
        .valid_o     (thid_free),
        .pop_data_o  (l15_threadid_o)
    );

    l15_store_align i_store_align (
        .req_cmd_i     (req_cmd_i),
        .req_addr_i    (req_addr_i),
        .req_size_i    (req_size_i),
        .req_wdata_i   (req_wdata_i),
        .req_be_i      (req_be_i),
        .l15_rqtype_o  (l15_rqtype_o),
        .l15_nc_o      (l15_nc_o),
        .l15_size_o    (l15_size_o),
        .l15_address_o (l15_address_o),
        .l15_data_o    (l15_data_o)
    );

    l15_resp_route i_resp_route (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .table_wr_i      (accept),
        .table_thid_i    (l15_threadid_o),
        .req_pid_i       (req_pid_i),
        .req_id_i        (req_id_i),
        .rtrn_val_i      (rtrn_val_i),
        .rtrn_type_i     (rtrn_type_i),
        .rtrn_threadid_i (rtrn_threadid_i),
        .rtrn_inval_i    (rtrn_inval_i),
        .inval_full_i    (inval_full),
        .resp_ready_i    (resp_ready_i),
        .l15_req_ack_o   (l15_req_ack_o),
        .resp_valid_o    (resp_valid_o),
        .resp_pid_o      (resp_pid_o),
        .resp_id_o       (resp_id_o),
        .resp_error_o    (resp_error_o),
        .thid_release_o  (thid_release),
        .inval_push_o    (inval_push)
    );

    l15_fifo #(
        .Depth     (InvalFifoDepth),
        .InitFill  (1'b0),
        .payload_t (addr_t)
    ) i_inval_fifo (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (inval_push),
        .push_data_i (rtrn_inval_addr_i),
        .pop_i       (inval_ready_i),
        .full_o      (inval_full),
        .valid_o     (inval_valid_o),
        .pop_data_o  (inval_addr_o)
    );

endmodule

/* l15_adapter_chk.sv */
// L1.5 adapter protocol assertions
`timescale 1ns/100ps

module l15_adapter_chk import l15_adapter_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        l15_val_i,
    input  logic        l15_ack_i,
    input  logic        req_ready_i,
    input  logic        resp_valid_i,
    input  logic        inval_valid_i,
    input  l15_rtrn_e   rtrn_type_i,
    input  l15_rqtype_e l15_rqtype_i,
    input  logic        l15_nc_i,
    input  size_t       l15_size_i,
    input  thid_t       l15_threadid_i,
    input  addr_t       l15_address_i,
    input  dword_t      l15_data_i
);

    logic pend_q;   // Request offered but not yet acked

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_q <= 1'b0;
        end else if (req_ready_i) begin
            pend_q <= 1'b0;
        end else if (l15_val_i) begin
            pend_q <= 1'b1;
        end
    end

    a_ready_on_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_ready_i |-> l15_ack_i)
        else $error("req_ready_o without l15_ack_i");

    a_no_evict_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resp_valid_i |-> (rtrn_type_i != RET_EVICT))
        else $error("resp_valid_o raised for an eviction return");

    a_reset_quiet: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> (!l15_val_i && !inval_valid_i))
        else $error("request or invalidation valid right after reset");

    a_fields_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (l15_val_i || pend_q) && !req_ready_i |=>
            $stable(l15_rqtype_i) && $stable(l15_nc_i) && $stable(l15_size_i) &&
            $stable(l15_threadid_i) && $stable(l15_address_i) && $stable(l15_data_i))
        else $error("L1.5 request fields changed before the ack");

endmodule

bind l15_adapter l15_adapter_chk i_chk (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .l15_val_i      (l15_val_o),
    .l15_ack_i      (l15_ack_i),
    .req_ready_i    (req_ready_o),
    .resp_valid_i   (resp_valid_o),
    .inval_valid_i  (inval_valid_o),
    .rtrn_type_i    (rtrn_type_i),
    .l15_rqtype_i   (l15_rqtype_o),
    .l15_nc_i       (l15_nc_o),
    .l15_size_i     (l15_size_o),
    .l15_threadid_i (l15_threadid_o),
    .l15_address_i  (l15_address_o),
    .l15_data_i     (l15_data_o)
);

/* tb_l15_adapter.sv */
// L1.5 adapter testbench
`timescale 1ns/100ps

module tb_l15_adapter import l15_adapter_pkg::*; ();

    localparam int NumReqs       = 300;
    localparam int TimeoutCycles = NumReqs * 60;
    localparam int InvalDepth    = 4;

    logic        clk_i;
    logic        rst_ni;
    logic        req_valid_i;
    logic        req_ready_o;
    pid_t        req_pid_i;
    mem_id_t     req_id_i;
    req_cmd_e    req_cmd_i;
    addr_t       req_addr_i;
    size_t       req_size_i;
    dword_t      req_wdata_i;
    be_t         req_be_i;
    logic        l15_val_o;
    l15_rqtype_e l15_rqtype_o;
    logic        l15_nc_o;
    size_t       l15_size_o;
    thid_t       l15_threadid_o;
    addr_t       l15_address_o;
    dword_t      l15_data_o;
    logic        l15_header_ack_i;
    logic        l15_ack_i;
    logic        rtrn_val_i;
    l15_rtrn_e   rtrn_type_i;
    thid_t       rtrn_threadid_i;
    dword_t      rtrn_data_i;
    logic        rtrn_inval_i;
    addr_t       rtrn_inval_addr_i;
    logic        l15_req_ack_o;
    logic        resp_valid_o;
    logic        resp_ready_i;
    pid_t        resp_pid_o;
    mem_id_t     resp_id_o;
    dword_t      resp_data_o;
    logic        resp_error_o;
    logic        inval_valid_o;
    logic        inval_ready_i;
    addr_t       inval_addr_o;

    integer    seed;
    int        errors;
    int        checks;
    int        cycle_cnt;
    int        req_issued;
    int        req_done;
    int        issue_limit;
    int        in_flight;   // Thread ids held by the L1.5 model
    int        ids_used;
    bit        req_pending;
    bit        hdr_seen;    // Header taken, ack still to come
    bit        rtrn_busy;
    bit        allow_rtrn;
    bit        inval_stall;

    // Request held by the requester model
    pid_t      cur_pid;
    mem_id_t   cur_id;
    req_cmd_e  cur_cmd;
    addr_t     cur_addr;
    size_t     cur_size;
    dword_t    cur_wdata;
    be_t       cur_be;

    // L1.5 side record of accepted requests
    bit        outstanding [NumThreadIds];
    pid_t      tab_pid     [NumThreadIds];
    mem_id_t   tab_id      [NumThreadIds];
    addr_t     tab_addr    [NumThreadIds];
    bit        tab_store   [NumThreadIds];

    // Return being offered
    l15_rtrn_e rt_type;
    thid_t     rt_tid;
    dword_t    rt_data;
    bit        rt_inval;
    addr_t     rt_inval_addr;

    addr_t     inval_q [$];   // Expected invalidation order

    l15_adapter #(
        .InvalFifoDepth (InvalDepth)
    ) i_dut (.*);

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    // 1, 2, 4 or 8 bytes on a naturally aligned offset
    function automatic be_t make_be(input logic [31:0] r);
        int n;
        int slots;
        n     = 1 << r[1:0];
        slots = 8 / n;
        make_be = be_t'(((1 << n) - 1) << (n * (int'(r[7:4]) % slots)));
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_request_fields();
        logic   is_st;
        logic   exp_nc;
        int     cnt;
        int     low;
        size_t  exp_size;
        addr_t  exp_addr;
        dword_t exp_data;
        cnt      = 0;
        low      = 8;
        is_st    = (cur_cmd == CMD_WRITE) || (cur_cmd == CMD_UNC_WRITE);
        exp_nc   = (cur_cmd == CMD_UNC_READ) || (cur_cmd == CMD_UNC_WRITE);
        exp_size = cur_size;
        exp_addr = cur_addr;
        exp_data = cur_wdata;
        for (int b = 0; b < 8; b++) begin
            if (cur_be[b]) begin
                cnt++;
                if (low == 8) begin
                    low = b;
                end
            end
        end
        if (is_st) begin
            exp_size = 3'd3;
            if (cnt < 8) begin
                exp_size      = (cnt == 1) ? 3'd0 : (cnt == 2) ? 3'd1 : 3'd2;
                exp_addr[2:0] = 3'(low);
                // Every byte lane repeats the written chunk
                for (int b = 0; b < 8; b++) begin
                    exp_data[8*b +: 8] = cur_wdata[8*(low + b % cnt) +: 8];
                end
            end
        end
        compare("l15_rqtype_o", l15_rqtype_o, is_st ? RQ_STORE : RQ_LOAD);
        compare("l15_nc_o", l15_nc_o, exp_nc);
        compare("l15_size_o", l15_size_o, exp_size);
        compare("l15_address_o", l15_address_o, exp_addr);
        compare("l15_data_o", l15_data_o, exp_data);
    endtask

    task automatic check_reset_state();
        @(negedge clk_i);
        compare("l15_val_o", l15_val_o, 1'b0);
        compare("req_ready_o", req_ready_o, 1'b0);
        compare("resp_valid_o", resp_valid_o, 1'b0);
        compare("inval_valid_o", inval_valid_o, 1'b0);
        compare("l15_req_ack_o", l15_req_ack_o, 1'b0);
    endtask

    task automatic run_cycle();
        logic        exp_val;
        logic        hdr_now;
        logic        exp_ready;
        logic        exp_ack;
        logic        exp_rv;
        logic        inval_full;
        logic        evict;
        logic        next_hdr;
        logic        next_ack;
        logic [31:0] r;
        thid_t       tid;
        int          start;
        bit          found;
        @(negedge clk_i);

        // Request handshake
        exp_val   = req_valid_i && !hdr_seen && (in_flight < NumThreadIds);
        hdr_now   = exp_val && l15_header_ack_i;
        exp_ready = (hdr_seen || hdr_now) && l15_ack_i;
        compare("l15_val_o", l15_val_o, exp_val);
        compare("req_ready_o", req_ready_o, exp_ready);
        if (exp_ready) begin
            check_request_fields();
            tid = l15_threadid_o;
            if (outstanding[tid]) begin
                errors++;
                $display("ERROR: thread id %0d handed out while still outstanding", tid);
            end
            outstanding[tid] = 1'b1;
            tab_pid[tid]     = cur_pid;
            tab_id[tid]      = cur_id;
            tab_addr[tid]    = cur_addr;
            tab_store[tid]   = (cur_cmd == CMD_WRITE) || (cur_cmd == CMD_UNC_WRITE);
            in_flight++;
            req_done++;
            req_pending = 1'b0;
        end
        hdr_seen = exp_ready ? 1'b0 : (hdr_seen || hdr_now);

        // Return path against the model FIFO occupancy
        inval_full = (inval_q.size() == InvalDepth);
        evict      = (rt_type == RET_EVICT);
        exp_ack    = 1'b0;
        exp_rv     = 1'b0;
        if (rtrn_busy) begin
            if (!rt_inval) begin
                exp_ack = resp_ready_i;
                exp_rv  = !evict;
            end else if (evict) begin
                exp_ack = !inval_full;   // Eviction alone only needs FIFO room
            end else begin
                exp_ack = !inval_full && resp_ready_i;
                exp_rv  = !inval_full;
            end
        end
        compare("l15_req_ack_o", l15_req_ack_o, exp_ack);
        compare("resp_valid_o", resp_valid_o, exp_rv);
        if (exp_rv) begin
            compare("resp_pid_o", resp_pid_o, tab_pid[rt_tid]);
            compare("resp_id_o", resp_id_o, tab_id[rt_tid]);
            compare("resp_data_o", resp_data_o, rt_data);
            compare("resp_error_o", resp_error_o, rt_type == RET_ERR);
        end

        compare("inval_valid_o", inval_valid_o, inval_q.size() > 0);
        if (inval_q.size() > 0) begin
            compare("inval_addr_o", inval_addr_o, inval_q[0]);
            if (inval_ready_i) begin
                void'(inval_q.pop_front());
            end
        end
        if (exp_ack) begin
            if (rt_inval) begin
                inval_q.push_back(rt_inval_addr);
            end
            if (!evict) begin
                outstanding[rt_tid] = 1'b0;
                in_flight--;
            end
            rtrn_busy = 1'b0;
        end

        // Next requester and L1.5 stimulus
        r = next_rand();
        if (!req_pending && req_issued < issue_limit && r[1:0] != 2'b00) begin
            cur_pid     = pid_t'(next_rand());
            cur_id      = mem_id_t'(next_rand());
            cur_cmd     = req_cmd_e'(r[3:2]);
            cur_addr    = addr_t'({next_rand(), next_rand()});
            cur_size    = size_t'(r[5:4]);
            cur_wdata   = {next_rand(), next_rand()};
            cur_be      = make_be(next_rand());
            req_pending = 1'b1;
            req_issued++;
        end
        next_hdr = !hdr_seen && req_pending && (r[8:7] == 2'b00);
        next_ack = (hdr_seen || next_hdr) && r[9];

        if (!rtrn_busy && allow_rtrn && r[10]) begin
            if (r[12:11] == 2'b00) begin
                rt_type       = RET_EVICT;   // Invalidation without a response
                rt_tid        = thid_t'(r[14:13]);
                rt_data       = '0;
                rt_inval      = 1'b1;
                rt_inval_addr = addr_t'({next_rand(), next_rand()}) & ~addr_t'(63);
                rtrn_busy     = 1'b1;
            end else if (in_flight > 0) begin
                start = int'(r[14:13]);
                found = 1'b0;
                for (int i = 0; i < NumThreadIds; i++) begin
                    if (!found && outstanding[(start + i) % NumThreadIds]) begin
                        found  = 1'b1;
                        rt_tid = thid_t'((start + i) % NumThreadIds);
                    end
                end
                rt_type = tab_store[rt_tid] ? RET_STORE_ACK : RET_LOAD;
                if (r[17:15] == 3'd0) begin
                    rt_type = RET_ERR;
                end
                rt_data       = {tab_addr[rt_tid][31:0], ~tab_addr[rt_tid][31:0]};
                rt_inval      = r[18];
                rt_inval_addr = addr_t'({next_rand(), next_rand()}) & ~addr_t'(63);
                rtrn_busy     = 1'b1;
            end
        end
        if (r[23:19] == 5'd0) begin
            inval_stall = !inval_stall;   // Long stalls fill the FIFO
        end

        @(posedge clk_i);
        req_valid_i       <= req_pending;
        req_pid_i         <= cur_pid;
        req_id_i          <= cur_id;
        req_cmd_i         <= cur_cmd;
        req_addr_i        <= cur_addr;
        req_size_i        <= cur_size;
        req_wdata_i       <= cur_wdata;
        req_be_i          <= cur_be;
        l15_header_ack_i  <= next_hdr;
        l15_ack_i         <= next_ack;
        rtrn_val_i        <= rtrn_busy;
        rtrn_type_i       <= rt_type;
        rtrn_threadid_i   <= rt_tid;
        rtrn_data_i       <= rt_data;
        rtrn_inval_i      <= rt_inval;
        rtrn_inval_addr_i <= rt_inval_addr;
        resp_ready_i      <= r[25] || r[26];
        inval_ready_i     <= !inval_stall && r[24];
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TimeoutCycles) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("ERROR: timeout after %0d cycles, %0d requests done", cycle_cnt, req_done);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed        = 74;
        errors      = 0;
        checks      = 0;
        req_issued  = 0;
        req_done    = 0;
        issue_limit = NumReqs;
        in_flight   = 0;
        ids_used    = 0;
        req_pending = 1'b0;
        hdr_seen    = 1'b0;
        rtrn_busy   = 1'b0;
        allow_rtrn  = 1'b1;
        inval_stall = 1'b0;
        for (int i = 0; i < NumThreadIds; i++) begin
            outstanding[i] = 1'b0;
        end
        cur_pid       = '0;
        cur_id        = '0;
        cur_cmd       = CMD_READ;
        cur_addr      = '0;
        cur_size      = '0;
        cur_wdata     = '0;
        cur_be        = '0;
        rt_type       = RET_LOAD;
        rt_tid        = '0;
        rt_data       = '0;
        rt_inval      = 1'b0;
        rt_inval_addr = '0;

        clk_i             = 1'b0;
        rst_ni            = 1'b0;
        req_valid_i       = 1'b0;
        req_pid_i         = '0;
        req_id_i          = '0;
        req_cmd_i         = CMD_READ;
        req_addr_i        = '0;
        req_size_i        = '0;
        req_wdata_i       = '0;
        req_be_i          = '0;
        l15_header_ack_i  = 1'b0;
        l15_ack_i         = 1'b0;
        rtrn_val_i        = 1'b0;
        rtrn_type_i       = RET_LOAD;
        rtrn_threadid_i   = '0;
        rtrn_data_i       = '0;
        rtrn_inval_i      = 1'b0;
        rtrn_inval_addr_i = '0;
        resp_ready_i      = 1'b0;
        inval_ready_i     = 1'b0;

        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        check_reset_state();

        while (!(req_done == NumReqs && in_flight == 0 &&
                 !rtrn_busy && inval_q.size() == 0)) begin
            run_cycle();
        end

        // With returns held off, all ids must be handed out again
        allow_rtrn  = 1'b0;
        issue_limit = NumReqs + NumThreadIds;
        while (req_done < issue_limit) begin
            run_cycle();
        end
        for (int i = 0; i < NumThreadIds; i++) begin
            if (outstanding[i]) begin
                ids_used++;
            end
        end
        if (ids_used != NumThreadIds) begin
            errors++;
            $display("ERROR: only %0d distinct thread ids usable after all returns", ids_used);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sources.f */
l15_adapter_pkg.sv
l15_req_fsm.sv
l15_fifo.sv
l15_store_align.sv
l15_resp_route.sv
l15_adapter.sv
l15_adapter_chk.sv
tb_l15_adapter.sv

/* Bender.yml */
package:
  name: l15_adapter

sources:
  - l15_adapter_pkg.sv
  - l15_req_fsm.sv
  - l15_fifo.sv
  - l15_store_align.sv
  - l15_resp_route.sv
  - l15_adapter.sv
  - target: test
    files:
      - l15_adapter_chk.sv
      - tb_l15_adapter.sv
